// ==== src.f ====
+incdir+common
common/lpc_sample_pkg.sv
common/lpc_ctrl_pkg.sv
hw/lpc_mem_ctrl.sv
hw/sample_ram.sv
hw/window_reader.sv
hw/frame_energy.sv
hw/lpc_buffer_top.sv
testbench/lpc_buffer_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the LPC sample buffer testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module lpc_buffer_tb -o lpc_buffer_tb > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/lpc_buffer_tb > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0

// ==== testbench/lpc_buffer_tb.sv ====
`include "lpc_consts.svh"

module lpc_buffer_tb import lpc_sample_pkg::*; ();

	localparam int NUM_SAMPLES = 1200;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_SPACING = 8;
	localparam int TIMEOUT_CYCLES = NUM_SAMPLES * MAX_SPACING + 2000 + RESET_CYCLES;
	// 80th strobe to first win_valid
	localparam int START_LATENCY = 4;
	localparam int WIN = `LPC_WINDOW_LEN;
	localparam int FRAME = `LPC_FRAME_LEN;

	logic       clock;
	logic       reset;
	logic       sample_valid;
	sample_t    sample_in;
	logic       win_valid;
	sample_t    win_sample;
	win_index_t win_index;
	logic       win_last;
	logic       energy_valid;
	energy_t    energy;

	logic [31:0] lfsr_state;
	sample_t     samples [0:NUM_SAMPLES-1];
	longint      cycle_count;
	int          first_q[$];
	longint      energy_q[$];
	longint      start_cycle_q[$];
	int          windows_queued;
	int          windows_seen;
	int          pos;
	int          first_idx;
	logic        energy_due;
	longint      energy_exp;

	lpc_buffer_top i_lpc_buffer_top (
		.clock        (clock),
		.reset        (reset),
		.sample_valid (sample_valid),
		.sample_in    (sample_in),
		.win_valid    (win_valid),
		.win_sample   (win_sample),
		.win_index    (win_index),
		.win_last     (win_last),
		.energy_valid (energy_valid),
		.energy       (energy)
	);

	initial clock = 1'b0;
	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	////////////////////////////////
	// Helpers
	////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] value;
		int i;
		value = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[14:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// Sum of squares over the window starting at sample first
	function automatic longint window_energy(input int first);
		longint sum;
		int k;
		sum = 0;
		for (k = 0; k < WIN; k++)
			sum += longint'(samples[first + k]) * longint'(samples[first + k]);
		return sum;
	endfunction

	task automatic compare_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	////////////////////////////////
	// Stimulus and model
	////////////////////////////////

	initial begin
		int n;
		int gap;
		logic [15:0] value;
		lfsr_state = 32'hdc34_12f4;
		cycle_count = 0;
		energy_due = 1'b0;
		reset = 1'b1;
		sample_valid = 1'b0;
		sample_in = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		for (n = 0; n < NUM_SAMPLES; n++) begin
			@(posedge clock);
			value = random_bits(16);
			sample_valid <= 1'b1;
			sample_in <= sample_t'(value);
			samples[n] = sample_t'(value);
			// Frame end with a full window stored
			if ((n + 1) % FRAME == 0 && n + 1 >= WIN) begin
				first_q.push_back(n + 1 - WIN);
				energy_q.push_back(window_energy(n + 1 - WIN));
				start_cycle_q.push_back(cycle_count + START_LATENCY);
				windows_queued++;
			end
			@(posedge clock);
			sample_valid <= 1'b0;
			gap = 4 + int'(random_bits(2));
			repeat (gap - 1) @(posedge clock);
		end
		while (windows_seen < windows_queued || energy_due)
			@(posedge clock);
		repeat (20) @(posedge clock);
		$display("TEST PASSED");
		$finish;
	end

	////////////////////////////////
	// Output monitor
	////////////////////////////////

	// Compare the outputs at the falling edge
	always @(negedge clock) begin
		if (reset) begin
			compare_value("win_valid in reset", 0, win_valid);
			compare_value("energy_valid in reset", 0, energy_valid);
		end else begin
			compare_value("energy_valid", energy_due, energy_valid);
			if (energy_due) begin
				compare_value("energy", energy_exp, energy);
				energy_due = 1'b0;
			end
			if (win_valid) begin
				if (pos == 0) begin
					if (first_q.size() == 0) begin
						$display("Window output appeared with no frame end to cause it");
						$display("TEST FAILED");
						$fatal(1, "unexpected window");
					end
					first_idx = first_q.pop_front();
					energy_exp = energy_q.pop_front();
					compare_value("window start cycle", start_cycle_q.pop_front(), cycle_count);
				end
				compare_value("win_index", pos, win_index);
				compare_value("win_sample", samples[first_idx + pos], win_sample);
				compare_value("win_last", pos == WIN - 1, win_last);
				if (pos == WIN - 1) begin
					pos = 0;
					windows_seen++;
					energy_due = 1'b1;
				end else begin
					pos++;
				end
			end else begin
				if (pos != 0)
					compare_value("win_valid within window", 1, win_valid);
				compare_value("win_last without valid", 0, win_last);
			end
		end
	end

	// Watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		$display("Timeout: the windows did not all come out in time");
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

endmodule

// ==== hw/lpc_buffer_top.sv ====
module lpc_buffer_top import lpc_sample_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       sample_valid,
	input  sample_t    sample_in,
	output logic       win_valid,
	output sample_t    win_sample,
	output win_index_t win_index,
	output logic       win_last,
	output logic       energy_valid,
	output energy_t    energy
);

	// Write side
	logic      wr_en;
	buf_addr_t wr_addr;
	sample_t   wr_data;

	// Window issue and read side
	logic      window_start;
	buf_addr_t window_base;
	logic      rd_en;
	buf_addr_t rd_addr;

	lpc_mem_ctrl i_lpc_mem_ctrl (
		.clock        (clock),
		.reset        (reset),
		.sample_valid (sample_valid),
		.sample_in    (sample_in),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.window_start (window_start),
		.window_base  (window_base)
	);

	// RAM output is the window sample stream
	sample_ram i_sample_ram (
		.clock   (clock),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (win_sample)
	);

	window_reader i_window_reader (
		.clock        (clock),
		.reset        (reset),
		.window_start (window_start),
		.window_base  (window_base),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.win_valid    (win_valid),
		.win_index    (win_index),
		.win_last     (win_last)
	);

	frame_energy i_frame_energy (
		.clock        (clock),
		.reset        (reset),
		.win_valid    (win_valid),
		.win_last     (win_last),
		.win_sample   (win_sample),
		.energy_valid (energy_valid),
		.energy       (energy)
	);

endmodule

// ==== hw/frame_energy.sv ====
`include "lpc_consts.svh"

module frame_energy import lpc_sample_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  logic    win_valid,
	input  logic    win_last,
	input  sample_t win_sample,
	output logic    energy_valid,
	output energy_t energy
);

	localparam int unsigned SQ_W = 2 * `LPC_SAMPLE_W;
	localparam int unsigned PAD_W = `LPC_ENERGY_W - SQ_W;

	logic signed [SQ_W-1:0] square;
	energy_t                acc;
	energy_t                sum_next;
	logic                   first;

	always_comb begin
		// Never negative, even for -32768
		square = win_sample * win_sample;
		sum_next = (first ? '0 : acc) + {{PAD_W{1'b0}}, square};
	end

	////////////////////////////////
	// Accumulator
	////////////////////////////////

	// First valid after win_last opens a new window
	always_ff @(posedge clock) begin
		if (reset) begin
			first <= 1'b1;
			energy_valid <= 1'b0;
		end else begin
			energy_valid <= win_valid && win_last;
			if (win_valid)
				first <= win_last;
		end
	end

	always_ff @(posedge clock) begin
		if (win_valid)
			acc <= sum_next;
		if (win_valid && win_last)
			energy <= sum_next;
	end

endmodule

// ==== hw/window_reader.sv ====
`include "lpc_consts.svh"

module window_reader import lpc_sample_pkg::*, lpc_ctrl_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       window_start,
	input  buf_addr_t  window_base,
	output logic       rd_en,
	output buf_addr_t  rd_addr,
	output logic       win_valid,
	output win_index_t win_index,
	output logic       win_last
);

	localparam int unsigned LAST_INDEX = `LPC_WINDOW_LEN - 1;

	reader_state_t         state;
	buf_addr_t             base;
	win_index_t            index;
	logic                  index_last;
	logic [`LPC_ADDR_W:0]  addr_sum;

	////////////////////////////////
	// Address generation
	////////////////////////////////

	always_comb begin
		addr_sum = base + index;
		// Window crosses entry 319 back to 0
		if (addr_sum >= (`LPC_ADDR_W+1)'(`LPC_BUF_DEPTH))
			rd_addr = buf_addr_t'(addr_sum - (`LPC_ADDR_W+1)'(`LPC_BUF_DEPTH));
		else
			rd_addr = buf_addr_t'(addr_sum);
	end

	assign rd_en = (state == READ);
	assign index_last = (index == win_index_t'(LAST_INDEX));

	////////////////////////////////
	// Sequencing
	////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			win_valid <= 1'b0;
			win_last <= 1'b0;
		end else begin
			// Strobes trail the read by the RAM latency
			win_valid <= rd_en;
			win_last <= rd_en && index_last;
			case (state)
				IDLE: begin
					if (window_start)
						state <= READ;
				end
				READ: begin
					if (index_last)
						state <= DRAIN;
				end
				DRAIN: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == IDLE && window_start) begin
			base <= window_base;
			index <= '0;
		end else if (rd_en && !index_last) begin
			index <= index + 1'b1;
		end
		win_index <= index;
	end

	// Producer spaced its samples too tightly
	start_while_busy: assert property (@(posedge clock) disable iff (reset)
		window_start |-> state == IDLE);

endmodule

// ==== hw/sample_ram.sv ====
`include "lpc_consts.svh"

module sample_ram import lpc_sample_pkg::*; (
	input  logic      clock,
	input  logic      wr_en,
	input  buf_addr_t wr_addr,
	input  sample_t   wr_data,
	input  logic      rd_en,
	input  buf_addr_t rd_addr,
	output sample_t   rd_data
);

	sample_t mem [0:`LPC_BUF_DEPTH-1];

	always_ff @(posedge clock) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// One cycle read latency
	always_ff @(posedge clock) begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

	////////////////////////////////
	// Address range
	////////////////////////////////

	// 9-bit addresses can reach past the 320 ring entries
	wr_addr_range: assert property (@(posedge clock)
		wr_en |-> wr_addr < buf_addr_t'(`LPC_BUF_DEPTH));

	rd_addr_range: assert property (@(posedge clock)
		rd_en |-> rd_addr < buf_addr_t'(`LPC_BUF_DEPTH));

endmodule

// ==== hw/lpc_mem_ctrl.sv ====
`include "lpc_consts.svh"

module lpc_mem_ctrl import lpc_sample_pkg::*, lpc_ctrl_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      sample_valid,
	input  sample_t   sample_in,
	output logic      wr_en,
	output buf_addr_t wr_addr,
	output sample_t   wr_data,
	output logic      window_start,
	output buf_addr_t window_base
);

	localparam int unsigned FILL_FRAMES = `LPC_WINDOW_LEN / `LPC_FRAME_LEN;
	localparam int unsigned SPARE_LEN = `LPC_BUF_DEPTH - `LPC_WINDOW_LEN;

	ctrl_state_t state;
	buf_addr_t   wr_ptr;
	buf_addr_t   ptr_next;
	buf_addr_t   base_next;
	logic [6:0]  frame_cnt;
	logic [1:0]  fill_count;
	logic        frame_end;

	////////////////////////////////
	// Write port
	////////////////////////////////

	// Sample lands in the RAM at the edge ending its strobe cycle
	assign wr_en = sample_valid;
	assign wr_addr = wr_ptr;
	assign wr_data = sample_in;

	always_comb begin
		// Pointer after this write, wrapping at the ring end
		if (wr_ptr == buf_addr_t'(`LPC_BUF_DEPTH - 1))
			ptr_next = '0;
		else
			ptr_next = wr_ptr + 1'b1;

		// Oldest window sample sits 240 entries behind the new pointer
		if (ptr_next >= buf_addr_t'(`LPC_WINDOW_LEN))
			base_next = ptr_next - buf_addr_t'(`LPC_WINDOW_LEN);
		else
			base_next = ptr_next + buf_addr_t'(SPARE_LEN);
	end

	assign frame_end = sample_valid && (frame_cnt == 7'(`LPC_FRAME_LEN - 1));

	////////////////////////////////
	// Frame and fill tracking
	////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FILL;
			wr_ptr <= '0;
			frame_cnt <= '0;
			fill_count <= '0;
			window_start <= 1'b0;
		end else begin
			window_start <= 1'b0;
			if (sample_valid) begin
				wr_ptr <= ptr_next;
				if (frame_end)
					frame_cnt <= '0;
				else
					frame_cnt <= frame_cnt + 1'b1;
			end
			if (frame_end) begin
				case (state)
					FILL: begin
						fill_count <= fill_count + 1'b1;
						// Third frame completes the first window
						if (fill_count == 2'(FILL_FRAMES - 1)) begin
							state <= RUN;
							window_start <= 1'b1;
						end
					end
					RUN: window_start <= 1'b1;
					default: state <= FILL;
				endcase
			end
		end
	end

	// Base only matters together with window_start
	always_ff @(posedge clock) begin
		if (frame_end)
			window_base <= base_next;
	end

endmodule

// ==== common/lpc_ctrl_pkg.sv ====
package lpc_ctrl_pkg;

	////////////////////////////////
	// Buffer controller
	////////////////////////////////

	// FILL until three frames are stored
	typedef enum logic {
		FILL,
		RUN
	} ctrl_state_t;

	////////////////////////////////
	// Window reader
	////////////////////////////////

	// DRAIN covers the last RAM latency cycle
	typedef enum logic [1:0] {
		IDLE,
		READ,
		DRAIN
	} reader_state_t;

endpackage

// ==== common/lpc_sample_pkg.sv ====
`include "lpc_consts.svh"

package lpc_sample_pkg;

	// Pre-processed speech sample
	typedef logic signed [`LPC_SAMPLE_W-1:0] sample_t;

	// Ring address, 0 to 319
	typedef logic [`LPC_ADDR_W-1:0] buf_addr_t;

	// Position within a window, 0 to 239
	typedef logic [$clog2(`LPC_WINDOW_LEN)-1:0] win_index_t;

	// Lag-0 autocorrelation term
	typedef logic [`LPC_ENERGY_W-1:0] energy_t;

endpackage

// ==== common/lpc_consts.svh ====
`ifndef LPC_CONSTS_SVH
`define LPC_CONSTS_SVH

////////////////////////////////
// Frame and window geometry
////////////////////////////////

// Samples per frame
`define LPC_FRAME_LEN 80

// Samples per analysis window, three frames
`define LPC_WINDOW_LEN 240

// Ring entries, window plus one spare frame
`define LPC_BUF_DEPTH 320

////////////////////////////////
// Data widths
////////////////////////////////

`define LPC_ADDR_W 9
`define LPC_SAMPLE_W 16

// 240 squares of full-scale negative need 38 bits
`define LPC_ENERGY_W 40

`endif
